// File: apb_if.sv
`timescale 1ns/1ps

interface apb_if;
   import fetch_pkg::*;

   addr_t paddr;
   logic  psel;
   logic  penable;
   logic  pwrite;
   word_t pwdata;
   word_t prdata;
   logic  pready;
   logic  pslverr;

   // memory side of the link.
   modport slave
   (
      input  paddr, psel, penable, pwrite, pwdata,
      output prdata, pready, pslverr
   );

endinterface

// File: bpu.sv
`timescale 1ns/1ps

module bpu #(parameter int btb_entries = 8)
(
   input logic      clk,
   input logic      rstn,
   bpu_if.predictor bp
);
   import fetch_pkg::*;

   localparam int idx_w = $clog2(btb_entries);
   localparam int tag_w = xlen - 2 - idx_w;

   logic [btb_entries-1:0] valid;
   logic [tag_w-1:0]       tag    [btb_entries];
   addr_t                  target [btb_entries];
   logic [1:0]             ctr    [btb_entries];

   logic [tag_w-1:0] lookup_tag;
   logic [tag_w-1:0] upd_tag;
   logic             lookup_hit;
   logic             upd_hit;

   assign lookup_tag = bp.lookup_pc[xlen-1:idx_w+2];
   assign upd_tag    = bp.upd_pc[xlen-1:idx_w+2];

   assign lookup_hit = valid[bp.lookup_idx] && (tag[bp.lookup_idx] == lookup_tag);
   assign upd_hit    = valid[bp.upd_idx] && (tag[bp.upd_idx] == upd_tag);

   // taken when the counter sits in the upper half.
   assign bp.pred_taken  = lookup_hit && ctr[bp.lookup_idx][1];
   assign bp.pred_target = target[bp.lookup_idx];

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         valid <= '0;
      else if (bp.upd_valid && bp.upd_taken)
         valid[bp.upd_idx] <= 1'b1; // allocate on a taken miss, no change on a hit.
   end

   always_ff @(posedge clk)
   begin
      if (bp.upd_valid)
      begin
         if (upd_hit)
         begin
            // saturating two-bit counter.
            if (bp.upd_taken && ctr[bp.upd_idx] != 2'd3)
               ctr[bp.upd_idx] <= ctr[bp.upd_idx] + 2'd1;
            else if (!bp.upd_taken && ctr[bp.upd_idx] != 2'd0)
               ctr[bp.upd_idx] <= ctr[bp.upd_idx] - 2'd1;
            if (bp.upd_taken)
               target[bp.upd_idx] <= bp.upd_target;
         end
         else if (bp.upd_taken)
         begin
            tag[bp.upd_idx]    <= upd_tag;
            target[bp.upd_idx] <= bp.upd_target;
            ctr[bp.upd_idx]    <= 2'd2;  // weakly taken.
         end
      end
   end

endmodule

// File: bpu_if.sv
`timescale 1ns/1ps

interface bpu_if #(parameter int btb_entries = 8);
   import fetch_pkg::*;

   localparam int idx_w = $clog2(btb_entries);

   // lookup group, answered in the same cycle.
   addr_t            lookup_pc;
   logic [idx_w-1:0] lookup_idx;
   logic             pred_taken;
   addr_t            pred_target;

   // update group, one cycle per resolved branch.
   logic             upd_valid;
   addr_t            upd_pc;
   logic [idx_w-1:0] upd_idx;
   logic             upd_taken;
   addr_t            upd_target;

   // words are 4-byte aligned, so the index starts at bit 2.
   assign lookup_idx = lookup_pc[idx_w+1:2];
   assign upd_idx    = upd_pc[idx_w+1:2];

   modport predictor
   (
      input  lookup_pc, lookup_idx, upd_valid, upd_pc, upd_idx, upd_taken, upd_target,
      output pred_taken, pred_target
   );

   modport fetch
   (
      output lookup_pc,
      input  pred_taken, pred_target
   );

endinterface

// File: fetch_pkg.sv
package fetch_pkg;

   // machine word width.
   localparam int xlen = 32;

   typedef logic [xlen-1:0] addr_t; // byte address.
   typedef logic [xlen-1:0] word_t; // instruction word.

   // major opcodes that pre-decode tells apart.
   typedef enum logic [6:0]
   {
      op_jal    = 7'b1101111,  // direct jump, target computed in fetch.
      op_jalr   = 7'b1100111,  // indirect jump, left to execute.
      op_branch = 7'b1100011,  // conditional branch, left to the predictor.
      op_other  = 7'b0000000
   } opcode_t;

   // fetch control state.
   typedef enum logic
   {
      fs_idle = 1'b0,  // after reset, waiting for run.
      fs_run  = 1'b1
   } fetch_state_t;

   // first address fetched out of reset.
   localparam addr_t reset_pc = '0;

   // byte offset between consecutive words.
   localparam addr_t word_step = 32'd4;

endpackage

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
   parameter int imem_words  = 64,
   parameter int btb_entries = 8
)
(
   input  logic             clk,
   input  logic             rstn,
   input  logic             run,
   input  fetch_pkg::addr_t paddr,
   input  logic             psel,
   input  logic             penable,
   input  logic             pwrite,
   input  fetch_pkg::word_t pwdata,
   output fetch_pkg::word_t prdata,
   output logic             pready,
   output logic             pslverr,
   input  logic             id_stall,
   input  logic             redirect,
   input  fetch_pkg::addr_t redirect_pc,
   input  logic             resolve_valid,
   input  fetch_pkg::addr_t resolve_pc,
   input  logic             resolve_taken,
   input  fetch_pkg::addr_t resolve_target,
   output logic             instr_valid,
   output fetch_pkg::word_t instr,
   output fetch_pkg::addr_t instr_pc,
   output logic             instr_pred
);
   import fetch_pkg::*;

   addr_t fetch_addr;
   word_t fetch_data;

   apb_if                              apb ();
   bpu_if #(.btb_entries(btb_entries)) bp ();

   // APB request side from the pins.
   assign apb.paddr   = paddr;
   assign apb.psel    = psel;
   assign apb.penable = penable;
   assign apb.pwrite  = pwrite;
   assign apb.pwdata  = pwdata;
   assign prdata      = apb.prdata;
   assign pready      = apb.pready;
   assign pslverr     = apb.pslverr;

   // branch outcomes from execute train the predictor.
   assign bp.upd_valid  = resolve_valid;
   assign bp.upd_pc     = resolve_pc;
   assign bp.upd_taken  = resolve_taken;
   assign bp.upd_target = resolve_target;

   imem_apb #(.imem_words(imem_words)) i_imem
   (
      .clk        (clk),
      .rstn       (rstn),
      .apb        (apb),
      .fetch_addr (fetch_addr),
      .fetch_data (fetch_data)
   );

   bpu #(.btb_entries(btb_entries)) i_bpu
   (
      .clk  (clk),
      .rstn (rstn),
      .bp   (bp)
   );

   ifetch i_ifetch
   (
      .clk         (clk),
      .rstn        (rstn),
      .run         (run),
      .id_stall    (id_stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .fetch_addr  (fetch_addr),
      .fetch_data  (fetch_data),
      .bp          (bp),
      .instr_valid (instr_valid),
      .instr       (instr),
      .instr_pc    (instr_pc),
      .instr_pred  (instr_pred)
   );

endmodule

// File: ifetch.sv
`timescale 1ns/1ps

module ifetch
(
   input  logic             clk,
   input  logic             rstn,
   input  logic             run,
   input  logic             id_stall,
   input  logic             redirect,
   input  fetch_pkg::addr_t redirect_pc,
   output fetch_pkg::addr_t fetch_addr,
   input  fetch_pkg::word_t fetch_data,
   bpu_if.fetch             bp,
   output logic             instr_valid,
   output fetch_pkg::word_t instr,
   output fetch_pkg::addr_t instr_pc,
   output logic             instr_pred
);
   import fetch_pkg::*;

   fetch_state_t state;
   addr_t        pc;
   addr_t        next_pc;
   addr_t        jal_imm;
   opcode_t      op;
   logic         use_pred;
   logic         fetch_en;
   logic         load;

   assign fetch_addr   = pc;
   assign bp.lookup_pc = pc;

   // major opcode of the word being fetched.
   always_comb
   begin
      case (fetch_data[6:0])
         op_jal:    op = op_jal;
         op_jalr:   op = op_jalr;
         op_branch: op = op_branch;
         default:   op = op_other;
      endcase
   end

   // J-type immediate, sign extended.
   assign jal_imm = {{12{fetch_data[31]}}, fetch_data[19:12], fetch_data[20],
                     fetch_data[30:21], 1'b0};

   // a direct jump wins over the predictor.
   assign use_pred = (op != op_jal) && bp.pred_taken;

   always_comb
   begin
      if (op == op_jal)
         next_pc = pc + jal_imm;
      else if (use_pred)
         next_pc = bp.pred_target;
      else
         next_pc = pc + word_step;
   end

   assign fetch_en = (state == fs_run) && run && !id_stall;
   assign load     = fetch_en && !redirect;

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state       <= fs_idle;
         pc          <= reset_pc;
         instr_valid <= 1'b0;
         instr_pred  <= 1'b0;
      end
      else
      begin
         if (state == fs_idle && run)
            state <= fs_run;
         else if (state == fs_run && !run)
            state <= fs_idle;

         if (redirect)
         begin
            pc          <= redirect_pc;
            instr_valid <= 1'b0;      // squash whatever was fetched this cycle.
         end
         else if (fetch_en)
         begin
            pc          <= next_pc;
            instr_valid <= 1'b1;
            instr_pred  <= use_pred;
         end
         else if (!run)
            instr_valid <= 1'b0;      // pc is kept for the restart.
      end
   end

   // word and its address toward decode; hold while stalled.
   always_ff @(posedge clk)
   begin
      if (load)
      begin
         instr    <= fetch_data;
         instr_pc <= pc;
      end
   end

endmodule

// File: imem_apb.sv
`timescale 1ns/1ps

module imem_apb #(parameter int imem_words = 64)
(
   input  logic            clk,
   input  logic            rstn,
   apb_if.slave            apb,
   input  fetch_pkg::addr_t fetch_addr,
   output fetch_pkg::word_t fetch_data
);
   import fetch_pkg::*;

   localparam int aw = (imem_words > 1) ? $clog2(imem_words) : 1;

   word_t mem [imem_words];

   logic [xlen-3:0] apb_idx;
   logic [xlen-3:0] fetch_idx;
   logic            apb_in_range;
   logic            fetch_in_range;
   logic            setup;
   logic            access;

   assign apb_idx        = apb.paddr[xlen-1:2];  // word index.
   assign fetch_idx      = fetch_addr[xlen-1:2];
   assign apb_in_range   = apb_idx < imem_words;
   assign fetch_in_range = fetch_idx < imem_words;

   assign setup  = apb.psel && !apb.penable;
   assign access = apb.psel && apb.penable;

   // no wait states.
   assign apb.pready  = 1'b1;
   assign apb.pslverr = access && !apb_in_range;

   // read data is captured in the setup phase, valid through access.
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         apb.prdata <= '0;
      else if (setup)
         apb.prdata <= (!apb.pwrite && apb_in_range) ? mem[apb_idx[aw-1:0]] : '0;
   end

   // writes land at the end of the access phase.
   always_ff @(posedge clk)
   begin
      if (access && apb.pwrite && apb_in_range)
         mem[apb_idx[aw-1:0]] <= apb.pwdata;
   end

   assign fetch_data = fetch_in_range ? mem[fetch_idx[aw-1:0]] : '0; // zero past the end.

endmodule

// File: run.sh
#!/usr/bin/env bash
# builds the fetch testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_fetch -f sim.f \
   && ./obj_dir/Vtb_fetch | tee /dev/stderr | grep -q "PASS: all tests" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: sim.f
fetch_pkg.sv
apb_if.sv
bpu_if.sv
imem_apb.sv
bpu.sv
ifetch.sv
fetch_top.sv
tb_fetch.sv

// File: tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;
   import fetch_pkg::*;

   localparam int imem_words  = 64;
   localparam int btb_entries = 8;
   localparam int idx_w       = $clog2(btb_entries);
   localparam int max_rows    = 8;
   localparam int max_cycles  = 4000; // apb load and readback take about 400, each row under 60.

   localparam addr_t branch_pc    = 32'h60;
   localparam addr_t train_target = 32'h80;

   logic  clk = 1'b0;
   logic  rstn, run, psel, penable, pwrite, pready, pslverr;
   logic  id_stall, redirect, resolve_valid, resolve_taken, instr_valid, instr_pred;
   addr_t paddr, redirect_pc, resolve_pc, resolve_target, instr_pc;
   word_t pwdata, prdata, instr;

   int seed = 53;
   int cycles = 0;
   int n_rows = 0;

   // stimulus table, one row per scenario, five expected addresses each.
   string t_name  [max_rows];
   int    t_mode  [max_rows]; // 0 none, 1 redirect running, 2 redirect stalled.
   int    t_upd   [max_rows]; // 0 none, 1 one taken resolve, 2 two not-taken resolves.
   bit    t_stall [max_rows];
   bit    t_pause [max_rows];
   addr_t t_pc    [max_rows][5];

   // reference predictor state.
   logic                  ref_valid [btb_entries];
   logic [31-idx_w-2:0]   ref_tag   [btb_entries];
   logic [1:0]            ref_ctr   [btb_entries];

   fetch_top #(.imem_words(imem_words), .btb_entries(btb_entries)) i_dut (.*);

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles == max_cycles)
      begin
         $display("timeout: the tests did not finish within %0d cycles", max_cycles);
         $display("FAIL: see errors above");
         $fatal(1, "timeout");
      end
   end

   task automatic check_word(input string what, input word_t exp, input word_t act);
      if (exp !== act)
      begin
         $display("ERROR %s: expected %h, actual %h", what, exp, act);
         $display("FAIL: see errors above");
         $fatal(1, "word mismatch");
      end
   endtask

   task automatic check_addr(input string what, input addr_t exp, input addr_t act);
      if (exp !== act)
      begin
         $display("ERROR %s: expected %h, actual %h", what, exp, act);
         $display("FAIL: see errors above");
         $fatal(1, "address mismatch");
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (exp !== act)
      begin
         $display("ERROR %s: expected %b, actual %b", what, exp, act);
         $display("FAIL: see errors above");
         $fatal(1, "bit mismatch");
      end
   endtask

   // J-type encoding with rd = x1.
   function automatic word_t jal_word(input int off);
      logic [20:0] o;
      o = off[20:0];
      return {o[20], o[10:1], o[11], o[19:12], 5'd1, op_jal};
   endfunction

   // program image: addi fillers tagged with their index, two jumps and one branch.
   function automatic word_t img(input int i);
      case (i)
         8:       return jal_word(16);   // 0x20 to 0x30.
         16:      return jal_word(-20);  // 0x40 back to 0x2c.
         24:      return {12'h0, 13'(i), op_branch};
         default: return {12'h0, 13'(i), 7'h13};
      endcase
   endfunction

   function automatic logic ref_taken(input addr_t pc);
      logic [idx_w-1:0] i;
      i = pc[idx_w+1:2];
      return ref_valid[i] && ref_tag[i] == pc[31:idx_w+2] && ref_ctr[i][1];
   endfunction

   // one APB transfer, setup then access; pready is sampled high in access.
   task automatic apb_access(input addr_t addr, input logic wr, input word_t wdata,
                             output word_t rdata, output logic err);
      @(posedge clk);
      #1;
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      check_bit("apb pready", 1'b1, pready);
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // execute stage resolving a branch; the reference predictor follows the same update.
   task automatic resolve(input addr_t pc, input logic taken, input addr_t target);
      logic [idx_w-1:0] i;
      i = pc[idx_w+1:2];
      @(posedge clk);
      #1;
      resolve_valid  = 1'b1;
      resolve_pc     = pc;
      resolve_taken  = taken;
      resolve_target = target;
      if (ref_valid[i] && ref_tag[i] == pc[31:idx_w+2])
      begin
         if (taken && ref_ctr[i] != 2'd3)
            ref_ctr[i] = ref_ctr[i] + 2'd1;
         else if (!taken && ref_ctr[i] != 2'd0)
            ref_ctr[i] = ref_ctr[i] - 2'd1;
      end
      else if (taken)
      begin
         ref_valid[i] = 1'b1;
         ref_tag[i]   = pc[31:idx_w+2];
         ref_ctr[i]   = 2'd2;
      end
      @(posedge clk);
      #1;
      resolve_valid = 1'b0;
   endtask

   task automatic add_row(input string name, input int mode, input int upd, input bit stall,
                          input bit pause, input addr_t a0, a1, a2, a3, a4);
      t_name[n_rows]  = name;
      t_mode[n_rows]  = mode;
      t_upd[n_rows]   = upd;
      t_stall[n_rows] = stall;
      t_pause[n_rows] = pause;
      t_pc[n_rows]    = '{a0, a1, a2, a3, a4};
      n_rows++;
   endtask

   initial
   begin
      word_t rd;
      logic  err;
      word_t w;
      int    k;
      int    held;
      rstn = 1'b0;
      run = 1'b0;
      {psel, penable, pwrite, paddr, pwdata} = '0;
      {id_stall, redirect, redirect_pc} = '0;
      {resolve_valid, resolve_pc, resolve_taken, resolve_target} = '0;
      foreach (ref_valid[i])
         ref_valid[i] = 1'b0;

      add_row("sequential", 0, 0, 1, 0, 32'h00, 32'h04, 32'h08, 32'h0c, 32'h10);
      add_row("jal forward", 1, 0, 0, 0, 32'h18, 32'h1c, 32'h20, 32'h30, 32'h34);
      add_row("jal backward", 1, 0, 1, 0, 32'h38, 32'h3c, 32'h40, 32'h2c, 32'h30);
      add_row("redirect stalled", 2, 0, 1, 0, 32'h48, 32'h4c, 32'h50, 32'h54, 32'h58);
      add_row("trained taken", 1, 1, 0, 0, 32'h58, 32'h5c, 32'h60, 32'h80, 32'h84);
      add_row("trained not taken", 1, 2, 1, 0, 32'h58, 32'h5c, 32'h60, 32'h64, 32'h68);
      add_row("run pause", 1, 0, 0, 1, 32'h00, 32'h04, 32'h08, 32'h0c, 32'h10);

      repeat (3) @(posedge clk);
      #1;
      rstn = 1'b1;

      for (int i = 0; i < imem_words; i++)
      begin
         apb_access(addr_t'(i * 4), 1'b1, img(i), rd, err);
         check_bit("apb write pslverr", 1'b0, err);
      end
      // one word past the end must error and leave the memory alone.
      apb_access(addr_t'(imem_words * 4), 1'b1, 32'hdead_beef, rd, err);
      check_bit("apb bad write pslverr", 1'b1, err);
      apb_access(addr_t'(imem_words * 4), 1'b0, '0, rd, err);
      check_bit("apb bad read pslverr", 1'b1, err);
      check_word("apb bad read data", '0, rd);
      for (int i = 0; i < imem_words; i++)
      begin
         apb_access(addr_t'(i * 4), 1'b0, '0, rd, err);
         check_bit("apb read pslverr", 1'b0, err);
         check_word("apb readback", img(i), rd);
      end

      for (int r = 0; r < n_rows; r++)
      begin
         for (int u = 0; u < t_upd[r]; u++)
            resolve(branch_pc, t_upd[r] == 1, train_target);
         if (t_mode[r] != 0)
         begin
            @(posedge clk);
            #1;
            redirect    = 1'b1;
            redirect_pc = t_pc[r][0];
            id_stall    = (t_mode[r] == 2);
         end
         k = 0;
         held = 0;
         while (k < 5)
         begin
            @(posedge clk);
            #1;
            redirect = 1'b0;
            if (t_pause[r] && k >= 2 && held < 6)
            begin
               run      = 1'b0;
               id_stall = 1'b0;
               held++;
            end
            else
            begin
               run      = 1'b1;
               id_stall = t_stall[r] && (($random(seed) & 3) == 0);
            end
            @(negedge clk);
            if (!run && held > 1)
               check_bit({t_name[r], " idle valid"}, 1'b0, instr_valid);
            if (instr_valid && !id_stall)
            begin
               w = img(int'(t_pc[r][k] >> 2));
               check_addr({t_name[r], " instr_pc"}, t_pc[r][k], instr_pc);
               check_word({t_name[r], " instr"}, w, instr);
               check_bit({t_name[r], " instr_pred"},
                         ref_taken(t_pc[r][k]) && w[6:0] != op_jal, instr_pred);
               k++;
            end
         end
      end

      $display("PASS: all tests");
      $finish;
   end

endmodule
